// File: logic/axis_in_pkg.sv
package axis_in_pkg;

   localparam int CSR_W      = 32;
   localparam int CSR_ADDR_W = 4;
   localparam int NWORDS_W   = 16;

   // one register per address
   typedef enum logic [CSR_ADDR_W-1:0] {
      SOFT_RESET     = 4'd0,
      ENABLE         = 4'd1,
      FIFO_THRESHOLD = 4'd2,
      DATA           = 4'd3,
      FIFO_EMPTY     = 4'd4,
      FIFO_FULL      = 4'd5,
      FIFO_LEVEL     = 4'd6,
      TLAST_DETECTED = 4'd7,
      NWORDS         = 4'd8
   } csr_addr_e;

   typedef struct packed {
      logic             valid;
      logic             we;
      csr_addr_e        addr;
      logic [CSR_W-1:0] wdata;
   } csr_req_t;

   // system domain to stream domain
   typedef struct packed {
      logic soft_reset;
      logic enable;
   } ctrl_t;

   // stream domain to system domain
   typedef struct packed {
      logic                tlast_detected;
      logic [NWORDS_W-1:0] nwords_gray;
   } status_t;

   // narrower codes are zero-extended by the caller
   function automatic logic [NWORDS_W-1:0] gray2bin(input logic [NWORDS_W-1:0] gray);
      logic [NWORDS_W-1:0] bin;
      bin[NWORDS_W-1] = gray[NWORDS_W-1];
      for (int i = NWORDS_W - 2; i >= 0; i--) begin
         bin[i] = bin[i+1] ^ gray[i];
      end
      return bin;
   endfunction

endpackage

// File: logic/cdc_sync.sv
module cdc_sync #(
   parameter type sync_t = logic
) (
   input  logic  clk_i,
   input  logic  arst_n_i,
   input  sync_t data_i,
   output sync_t data_o
);

   // first stage may go metastable
   sync_t meta_q;

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         meta_q <= '0;
         data_o <= '0;
      end else begin
         meta_q <= data_i;
         data_o <= meta_q;
      end
   end

endmodule

// File: logic/async_fifo.sv
module async_fifo
   import axis_in_pkg::*;
#(
   parameter int DATA_W      = 32,
   parameter int FIFO_ADDR_W = 4
) (
   input  logic                  arst_n_i,
   // write side
   input  logic                  w_clk_i,
   input  logic                  w_rst_i,
   input  logic                  w_en_i,
   input  logic [DATA_W-1:0]     w_data_i,
   output logic                  w_full_o,
   // read side
   input  logic                  r_clk_i,
   input  logic                  r_rst_i,
   input  logic                  r_en_i,
   output logic [DATA_W-1:0]     r_data_o,
   output logic                  r_empty_o,
   output logic                  r_full_o,
   output logic [FIFO_ADDR_W:0]  r_level_o
);

   // one extra bit tells full from empty
   localparam int PTR_W = FIFO_ADDR_W + 1;

   logic [DATA_W-1:0] mem [2**FIFO_ADDR_W];

   logic [PTR_W-1:0] w_bin;
   logic [PTR_W-1:0] w_gray;
   logic [PTR_W-1:0] w_bin_next;
   logic [PTR_W-1:0] r_gray_wsync;
   logic             w_push;

   logic [PTR_W-1:0] r_bin;
   logic [PTR_W-1:0] r_gray;
   logic [PTR_W-1:0] r_bin_next;
   logic [PTR_W-1:0] w_gray_rsync;
   logic [PTR_W-1:0] w_bin_rsync;
   logic             r_pop;

   // write side
   assign w_full_o   = w_gray == {~r_gray_wsync[PTR_W-1:PTR_W-2], r_gray_wsync[PTR_W-3:0]};
   assign w_push     = w_en_i & ~w_full_o;
   assign w_bin_next = w_bin + PTR_W'(1);

   always_ff @(posedge w_clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         w_bin  <= '0;
         w_gray <= '0;
      end else if (w_rst_i) begin
         w_bin  <= '0;
         w_gray <= '0;
      end else if (w_push) begin
         w_bin  <= w_bin_next;
         w_gray <= w_bin_next ^ (w_bin_next >> 1);
      end
   end

   always_ff @(posedge w_clk_i) begin
      if (w_push) begin
         mem[w_bin[FIFO_ADDR_W-1:0]] <= w_data_i;
      end
   end

   cdc_sync #(
      .sync_t(logic [PTR_W-1:0])
   ) u_rptr_sync (
      .clk_i   (w_clk_i),
      .arst_n_i(arst_n_i),
      .data_i  (r_gray),
      .data_o  (r_gray_wsync)
   );

   // read side
   assign r_empty_o  = r_gray == w_gray_rsync;
   assign r_pop      = r_en_i & ~r_empty_o;
   assign r_bin_next = r_bin + PTR_W'(1);

   assign w_bin_rsync = PTR_W'(gray2bin(NWORDS_W'(w_gray_rsync)));
   assign r_level_o   = w_bin_rsync - r_bin;
   assign r_full_o    = r_level_o == PTR_W'(2**FIFO_ADDR_W);

   always_ff @(posedge r_clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         r_bin  <= '0;
         r_gray <= '0;
      end else if (r_rst_i) begin
         r_bin  <= '0;
         r_gray <= '0;
      end else if (r_pop) begin
         r_bin  <= r_bin_next;
         r_gray <= r_bin_next ^ (r_bin_next >> 1);
      end
   end

   // output word holds until the next pop
   always_ff @(posedge r_clk_i) begin
      if (r_pop) begin
         r_data_o <= mem[r_bin[FIFO_ADDR_W-1:0]];
      end
   end

   cdc_sync #(
      .sync_t(logic [PTR_W-1:0])
   ) u_wptr_sync (
      .clk_i   (r_clk_i),
      .arst_n_i(arst_n_i),
      .data_i  (w_gray),
      .data_o  (w_gray_rsync)
   );

endmodule

// File: logic/stream_capture.sv
module stream_capture
   import axis_in_pkg::*;
#(
   parameter int DATA_W = 32
) (
   input  logic    axis_clk_i,
   input  logic    arst_n_i,
   input  ctrl_t   ctrl_i,
   input  logic    tvalid_i,
   input  logic    tlast_i,
   input  logic    fifo_full_i,
   output logic    tready_o,
   output logic    fifo_write_o,
   output status_t status_o
);

   logic [NWORDS_W-1:0] count_q;
   logic [NWORDS_W-1:0] count_next;
   logic                count_en;

   // a stream word must fit one register read
   if (DATA_W > CSR_W) begin : g_width_check
      $error("stream data wider than the register bus");
   end

   assign tready_o     = ctrl_i.enable & ~fifo_full_i;
   assign fifo_write_o = tvalid_i & tready_o;

   // the tlast beat itself still counts
   assign count_en   = fifo_write_o & ~status_o.tlast_detected;
   assign count_next = count_q + NWORDS_W'(1);

   always_ff @(posedge axis_clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         count_q  <= '0;
         status_o <= '0;
      end else if (ctrl_i.soft_reset) begin
         count_q  <= '0;
         status_o <= '0;
      end else begin
         // step output that stays set until soft reset
         if (fifo_write_o && tlast_i) begin
            status_o.tlast_detected <= 1'b1;
         end
         if (count_en) begin
            count_q              <= count_next;
            status_o.nwords_gray <= count_next ^ (count_next >> 1);
         end
      end
   end

endmodule

// File: logic/read_ctrl.sv
module read_ctrl #(
   parameter int DATA_W = 32
) (
   input  logic              clk_i,
   input  logic              arst_n_i,
   input  logic              soft_rst_i,
   input  logic              fifo_empty_i,
   input  logic [DATA_W-1:0] fifo_data_i,
   input  logic              dma_tready_i,
   input  logic              cpu_pop_i,
   output logic              fifo_read_o,
   output logic [DATA_W-1:0] dma_tdata_o,
   output logic              dma_tvalid_o,
   output logic [DATA_W-1:0] held_data_o
);

   typedef enum logic {
      S_FETCH,
      S_HOLD
   } state_e;

   state_e state_q;
   state_e state_next;
   logic   pop;

   // dma and cpu in the same cycle is one pop
   assign pop = dma_tvalid_o & (dma_tready_i | cpu_pop_i);

   always_comb begin
      state_next  = state_q;
      fifo_read_o = 1'b0;
      case (state_q)
         S_FETCH: begin
            if (!fifo_empty_i) begin
               fifo_read_o = 1'b1;
               state_next  = S_HOLD;
            end
         end
         default: begin
            if (pop) begin
               // refill at once so no gap cycle
               if (!fifo_empty_i) begin
                  fifo_read_o = 1'b1;
               end else begin
                  state_next = S_FETCH;
               end
            end
         end
      endcase
   end

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         state_q <= S_FETCH;
      end else if (soft_rst_i) begin
         state_q <= S_FETCH;
      end else begin
         state_q <= state_next;
      end
   end

   // the fifo output register is the held word
   assign dma_tvalid_o = state_q == S_HOLD;
   assign dma_tdata_o  = fifo_data_i;
   assign held_data_o  = dma_tvalid_o ? fifo_data_i : '0;

endmodule

// File: logic/csr_block.sv
module csr_block
   import axis_in_pkg::*;
#(
   parameter int DATA_W      = 32,
   parameter int FIFO_ADDR_W = 4
) (
   input  logic                 clk_i,
   input  logic                 arst_n_i,
   input  csr_req_t             csr_req_i,
   input  logic [DATA_W-1:0]    held_data_i,
   input  logic                 fifo_empty_i,
   input  logic                 fifo_full_i,
   input  logic [FIFO_ADDR_W:0] fifo_level_i,
   input  status_t              status_i,
   output logic [CSR_W-1:0]     csr_rdata_o,
   output logic                 csr_rvalid_o,
   output ctrl_t                ctrl_o,
   output logic                 cpu_pop_o,
   output logic                 interrupt_o
);

   logic [FIFO_ADDR_W:0] threshold_q;
   logic [NWORDS_W-1:0]  nwords_bin;
   logic [CSR_W-1:0]     rdata;
   logic                 wr;
   logic                 rd;

   assign wr = csr_req_i.valid & csr_req_i.we;
   assign rd = csr_req_i.valid & ~csr_req_i.we;

   assign cpu_pop_o  = rd && csr_req_i.addr == DATA;
   assign nwords_bin = gray2bin(status_i.nwords_gray);

   // zero threshold disables the interrupt
   assign interrupt_o = (threshold_q != '0) && (fifo_level_i >= threshold_q);

   always_comb begin
      case (csr_req_i.addr)
         SOFT_RESET:     rdata = CSR_W'(ctrl_o.soft_reset);
         ENABLE:         rdata = CSR_W'(ctrl_o.enable);
         FIFO_THRESHOLD: rdata = CSR_W'(threshold_q);
         DATA:           rdata = CSR_W'(held_data_i);
         FIFO_EMPTY:     rdata = CSR_W'(fifo_empty_i);
         FIFO_FULL:      rdata = CSR_W'(fifo_full_i);
         FIFO_LEVEL:     rdata = CSR_W'(fifo_level_i);
         TLAST_DETECTED: rdata = CSR_W'(status_i.tlast_detected);
         NWORDS:         rdata = CSR_W'(nwords_bin);
         default:        rdata = '0;
      endcase
   end

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         ctrl_o       <= '0;
         threshold_q  <= '0;
         csr_rvalid_o <= 1'b0;
         csr_rdata_o  <= '0;
      end else begin
         // response one cycle after the read
         csr_rvalid_o <= rd;
         if (rd) begin
            csr_rdata_o <= rdata;
         end
         if (wr) begin
            case (csr_req_i.addr)
               SOFT_RESET:     ctrl_o.soft_reset <= csr_req_i.wdata[0];
               ENABLE:         ctrl_o.enable     <= csr_req_i.wdata[0];
               FIFO_THRESHOLD: threshold_q       <= csr_req_i.wdata[FIFO_ADDR_W:0];
               default: ;
            endcase
         end
      end
   end

endmodule

// File: logic/axis_stream_in.sv
module axis_stream_in
   import axis_in_pkg::*;
#(
   parameter int DATA_W      = 32,
   parameter int FIFO_ADDR_W = 4
) (
   input  logic              clk_i,
   input  logic              axis_clk_i,
   input  logic              arst_n_i,
   // stream input
   input  logic [DATA_W-1:0] axis_tdata_i,
   input  logic              axis_tvalid_i,
   input  logic              axis_tlast_i,
   output logic              axis_tready_o,
   // dma output
   output logic [DATA_W-1:0] dma_tdata_o,
   output logic              dma_tvalid_o,
   input  logic              dma_tready_i,
   // register bus
   input  csr_req_t          csr_req_i,
   output logic [CSR_W-1:0]  csr_rdata_o,
   output logic              csr_rvalid_o,
   output logic              interrupt_o
);

   ctrl_t                ctrl_sys;
   ctrl_t                ctrl_axis;
   status_t              status_axis;
   status_t              status_sys;
   logic                 fifo_write;
   logic                 fifo_full_w;
   logic                 fifo_read;
   logic [DATA_W-1:0]    fifo_data;
   logic                 fifo_empty;
   logic                 fifo_full_r;
   logic [FIFO_ADDR_W:0] fifo_level;
   logic [DATA_W-1:0]    held_data;
   logic                 cpu_pop;

   csr_block #(
      .DATA_W     (DATA_W),
      .FIFO_ADDR_W(FIFO_ADDR_W)
   ) u_csr (
      .clk_i       (clk_i),
      .arst_n_i    (arst_n_i),
      .csr_req_i   (csr_req_i),
      .held_data_i (held_data),
      .fifo_empty_i(fifo_empty),
      .fifo_full_i (fifo_full_r),
      .fifo_level_i(fifo_level),
      .status_i    (status_sys),
      .csr_rdata_o (csr_rdata_o),
      .csr_rvalid_o(csr_rvalid_o),
      .ctrl_o      (ctrl_sys),
      .cpu_pop_o   (cpu_pop),
      .interrupt_o (interrupt_o)
   );

   // control into the stream domain
   cdc_sync #(
      .sync_t(ctrl_t)
   ) u_ctrl_sync (
      .clk_i   (axis_clk_i),
      .arst_n_i(arst_n_i),
      .data_i  (ctrl_sys),
      .data_o  (ctrl_axis)
   );

   // flag and gray count back to the system domain
   cdc_sync #(
      .sync_t(status_t)
   ) u_status_sync (
      .clk_i   (clk_i),
      .arst_n_i(arst_n_i),
      .data_i  (status_axis),
      .data_o  (status_sys)
   );

   stream_capture #(
      .DATA_W(DATA_W)
   ) u_capture (
      .axis_clk_i  (axis_clk_i),
      .arst_n_i    (arst_n_i),
      .ctrl_i      (ctrl_axis),
      .tvalid_i    (axis_tvalid_i),
      .tlast_i     (axis_tlast_i),
      .fifo_full_i (fifo_full_w),
      .tready_o    (axis_tready_o),
      .fifo_write_o(fifo_write),
      .status_o    (status_axis)
   );

   async_fifo #(
      .DATA_W     (DATA_W),
      .FIFO_ADDR_W(FIFO_ADDR_W)
   ) u_fifo (
      .arst_n_i (arst_n_i),
      .w_clk_i  (axis_clk_i),
      .w_rst_i  (ctrl_axis.soft_reset),
      .w_en_i   (fifo_write),
      .w_data_i (axis_tdata_i),
      .w_full_o (fifo_full_w),
      .r_clk_i  (clk_i),
      .r_rst_i  (ctrl_sys.soft_reset),
      .r_en_i   (fifo_read),
      .r_data_o (fifo_data),
      .r_empty_o(fifo_empty),
      .r_full_o (fifo_full_r),
      .r_level_o(fifo_level)
   );

   read_ctrl #(
      .DATA_W(DATA_W)
   ) u_read (
      .clk_i       (clk_i),
      .arst_n_i    (arst_n_i),
      .soft_rst_i  (ctrl_sys.soft_reset),
      .fifo_empty_i(fifo_empty),
      .fifo_data_i (fifo_data),
      .dma_tready_i(dma_tready_i),
      .cpu_pop_i   (cpu_pop),
      .fifo_read_o (fifo_read),
      .dma_tdata_o (dma_tdata_o),
      .dma_tvalid_o(dma_tvalid_o),
      .held_data_o (held_data)
   );

endmodule

// File: testbench/tb_clock_gen.sv
module tb_clock_gen #(
   parameter int PERIOD = 100,
   parameter int OFFSET = 0
) (
   output logic clk_o
);

   initial begin
      clk_o = 1'b0;
      #(OFFSET);
      forever begin
         #(PERIOD / 2);
         clk_o = ~clk_o;
      end
   end

endmodule

// File: testbench/axis_stream_in_asserts.sv
module axis_stream_in_asserts #(
   parameter int DATA_W = 32
) (
   input logic              clk_i,
   input logic              arst_n_i,
   input logic              soft_rst_i,
   input logic              cpu_pop_i,
   input logic              axis_tready_i,
   input logic [DATA_W-1:0] dma_tdata_i,
   input logic              dma_tvalid_i,
   input logic              dma_tready_i,
   input logic              csr_rvalid_i,
   input logic              interrupt_i
);

   int fail_count = 0;

   // a cpu pop or soft reset may legally move the held word
   property dma_hold_p;
      @(posedge clk_i) disable iff (!arst_n_i || soft_rst_i)
         dma_tvalid_i && !dma_tready_i && !cpu_pop_i |=> dma_tvalid_i && $stable(dma_tdata_i);
   endproperty

   property rvalid_single_p;
      @(posedge clk_i) disable iff (!arst_n_i)
         csr_rvalid_i |=> !csr_rvalid_i;
   endproperty

   property ctrl_known_p;
      @(posedge clk_i) disable iff (!arst_n_i)
         !$isunknown({axis_tready_i, dma_tvalid_i, csr_rvalid_i, interrupt_i});
   endproperty

   a_dma_hold: assert property (dma_hold_p)
      else begin
         $error("dma word or valid changed while the DMA port was stalled");
         fail_count++;
      end
   a_rvalid_single: assert property (rvalid_single_p)
      else begin
         $error("register read response lasted more than one cycle");
         fail_count++;
      end
   a_ctrl_known: assert property (ctrl_known_p)
      else begin
         $error("control output is unknown after reset");
         fail_count++;
      end

endmodule

bind axis_stream_in axis_stream_in_asserts #(
   .DATA_W(DATA_W)
) u_asserts (
   .clk_i        (clk_i),
   .arst_n_i     (arst_n_i),
   .soft_rst_i   (ctrl_sys.soft_reset),
   .cpu_pop_i    (cpu_pop),
   .axis_tready_i(axis_tready_o),
   .dma_tdata_i  (dma_tdata_o),
   .dma_tvalid_i (dma_tvalid_o),
   .dma_tready_i (dma_tready_i),
   .csr_rvalid_i (csr_rvalid_o),
   .interrupt_i  (interrupt_o)
);

// File: testbench/axis_stream_in_tb.sv
module axis_stream_in_tb
   import axis_in_pkg::*;
();

   localparam int DATA_W      = 32;
   localparam int FIFO_ADDR_W = 4;
   localparam int DEPTH       = 2**FIFO_ADDR_W;

   logic              clk;
   logic              axis_clk;
   logic              arst_n;
   logic [DATA_W-1:0] axis_tdata;
   logic              axis_tvalid;
   logic              axis_tlast;
   logic              axis_tready;
   logic [DATA_W-1:0] dma_tdata;
   logic              dma_tvalid;
   logic              dma_tready;
   csr_req_t          csr_req;
   logic [CSR_W-1:0]  csr_rdata;
   logic              csr_rvalid;
   logic              interrupt;

   logic [31:0]       rng;
   int                errors;
   int                checks;
   logic [DATA_W-1:0] sent_q[$];
   logic [DATA_W-1:0] rx_q[$];

   tb_clock_gen #(.PERIOD(100), .OFFSET(0)) u_sys_clk (.clk_o(clk));
   tb_clock_gen #(.PERIOD(100), .OFFSET(30)) u_axis_clk (.clk_o(axis_clk));

   axis_stream_in #(
      .DATA_W     (DATA_W),
      .FIFO_ADDR_W(FIFO_ADDR_W)
   ) dut (
      .clk_i        (clk),
      .axis_clk_i   (axis_clk),
      .arst_n_i     (arst_n),
      .axis_tdata_i (axis_tdata),
      .axis_tvalid_i(axis_tvalid),
      .axis_tlast_i (axis_tlast),
      .axis_tready_o(axis_tready),
      .dma_tdata_o  (dma_tdata),
      .dma_tvalid_o (dma_tvalid),
      .dma_tready_i (dma_tready),
      .csr_req_i    (csr_req),
      .csr_rdata_o  (csr_rdata),
      .csr_rvalid_o (csr_rvalid),
      .interrupt_o  (interrupt)
   );

   function automatic logic [31:0] next_rand();
      rng = rng ^ (rng << 13);
      rng = rng ^ (rng >> 17);
      rng = rng ^ (rng << 5);
      return rng;
   endfunction

   task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
      checks++;
      assert (got === exp) else begin
         $display("Fail: %s got %h expected %h", name, got, exp);
         errors++;
      end
   endtask

   task automatic check_true(input logic cond, input string what);
      checks++;
      assert (cond) else begin
         $display("Error: %s", what);
         errors++;
      end
   endtask

   task automatic wait_cycles(input int n);
      repeat (n) @(posedge clk);
   endtask

   task automatic csr_write(input csr_addr_e reg_addr, input logic [CSR_W-1:0] data);
      @(posedge clk);
      csr_req <= '{valid: 1'b1, we: 1'b1, addr: reg_addr, wdata: data};
      @(posedge clk);
      csr_req <= '0;
   endtask

   task automatic csr_read(input csr_addr_e reg_addr, output logic [CSR_W-1:0] data);
      int n;
      @(posedge clk);
      csr_req <= '{valid: 1'b1, we: 1'b0, addr: reg_addr, wdata: '0};
      @(posedge clk);
      csr_req <= '0;
      n = 0;
      @(negedge clk);
      while (!csr_rvalid && n < 10) begin
         @(negedge clk);
         n++;
      end
      check_true(csr_rvalid, "no response to a register read before the timeout");
      check_true(n == 0, "register read response came later than the cycle after the request");
      data = csr_rdata;
   endtask

   // called on an axis edge and returns on the edge that takes the beat
   task automatic send_beat(input logic [DATA_W-1:0] d, input logic last,
                            input int max_wait, output logic ok);
      int n;
      axis_tdata  <= d;
      axis_tlast  <= last;
      axis_tvalid <= 1'b1;
      n  = 0;
      ok = 1'b0;
      while (!ok && n < max_wait) begin
         @(negedge axis_clk);
         ok = axis_tready;
         n++;
      end
      @(posedge axis_clk);
   endtask

   // last_beat counts from 1 and zero means no tlast
   task automatic send_words(input int n_words, input int last_beat);
      logic [DATA_W-1:0] d;
      logic              ok;
      @(posedge axis_clk);
      for (int i = 0; i < n_words; i++) begin
         d = next_rand();
         sent_q.push_back(d);
         send_beat(d, i == last_beat - 1, 50, ok);
         check_true(ok, "stream beat was not accepted before the timeout");
      end
      axis_tvalid <= 1'b0;
      axis_tlast  <= 1'b0;
   endtask

   task automatic collect_dma(input int n_words, input logic random_ready);
      int          n;
      logic [31:0] r;
      n = 0;
      while (rx_q.size() < n_words && n < 3000) begin
         @(posedge clk);
         r = next_rand();
         dma_tready <= random_ready ? (r[0] | r[1]) : 1'b1;
         @(negedge clk);
         if (dma_tvalid && dma_tready) begin
            rx_q.push_back(dma_tdata);
         end
         n++;
      end
      @(posedge clk);
      dma_tready <= 1'b0;
      check_true(rx_q.size() == n_words, "DMA port delivered too few words before the timeout");
   endtask

   task automatic compare_words();
      check_eq("received word count", rx_q.size(), sent_q.size());
      for (int i = 0; i < rx_q.size() && i < sent_q.size(); i++) begin
         check_eq("dma_tdata_o", rx_q[i], sent_q[i]);
      end
      rx_q.delete();
      sent_q.delete();
   endtask

   task automatic apply_soft_reset();
      csr_write(SOFT_RESET, 1);
      wait_cycles(8);
      csr_write(SOFT_RESET, 0);
      wait_cycles(8);
   endtask

   task automatic finish_test(input string name, input int err_start);
      $display("test %s done, %0d errors", name, errors - err_start);
   endtask

   task automatic test_reset_state();
      int               e0;
      logic [CSR_W-1:0] rd;
      e0 = errors;
      wait_cycles(4);
      @(negedge clk);
      check_eq("axis_tready_o", axis_tready, 0);
      check_eq("dma_tvalid_o", dma_tvalid, 0);
      check_eq("interrupt_o", interrupt, 0);
      csr_read(FIFO_EMPTY, rd);
      check_eq("FIFO_EMPTY", rd, 1);
      csr_read(NWORDS, rd);
      check_eq("NWORDS", rd, 0);
      finish_test("reset_state", e0);
   endtask

   task automatic test_enable_order();
      int   e0;
      logic ready_seen;
      e0         = errors;
      ready_seen = 1'b0;
      @(posedge axis_clk);
      axis_tdata  <= 32'h0;
      axis_tvalid <= 1'b1;
      repeat (10) begin
         @(negedge axis_clk);
         ready_seen = ready_seen | axis_tready;
      end
      @(posedge axis_clk);
      axis_tvalid <= 1'b0;
      check_eq("axis_tready_o", ready_seen, 0);
      csr_write(ENABLE, 1);
      fork
         send_words(40, 0);
         collect_dma(40, 1'b1);
      join
      compare_words();
      finish_test("enable_order", e0);
   endtask

   task automatic test_backpressure();
      int                e0;
      int                accepted;
      int                attempts;
      logic              ok;
      logic              stalled;
      logic [DATA_W-1:0] d;
      logic [CSR_W-1:0]  rd;
      e0       = errors;
      accepted = 0;
      attempts = 0;
      stalled  = 1'b0;
      @(posedge axis_clk);
      while (!stalled && attempts < 30) begin
         d = next_rand();
         send_beat(d, 1'b0, 20, ok);
         if (ok) begin
            sent_q.push_back(d);
            accepted++;
         end else begin
            stalled = 1'b1;
         end
         attempts++;
      end
      axis_tvalid <= 1'b0;
      check_eq("accepted words", accepted, DEPTH + 1);
      csr_read(FIFO_FULL, rd);
      check_eq("FIFO_FULL", rd, 1);
      collect_dma(accepted, 1'b1);
      compare_words();
      finish_test("backpressure", e0);
   endtask

   task automatic test_tlast_count();
      int               e0;
      logic [CSR_W-1:0] rd;
      e0 = errors;
      // start from a cleared counter
      apply_soft_reset();
      fork
         send_words(8, 5);
         collect_dma(8, 1'b1);
      join
      compare_words();
      wait_cycles(5);
      csr_read(TLAST_DETECTED, rd);
      check_eq("TLAST_DETECTED", rd, 1);
      csr_read(NWORDS, rd);
      check_eq("NWORDS", rd, 5);
      finish_test("tlast_count", e0);
   endtask

   task automatic test_cpu_interrupt();
      int               e0;
      int               n;
      int               level_exp;
      logic [CSR_W-1:0] rd;
      e0 = errors;
      csr_write(FIFO_THRESHOLD, 4);
      @(negedge clk);
      check_eq("interrupt_o", interrupt, 0);
      send_words(6, 0);
      n = 0;
      while (!interrupt && n < 50) begin
         @(negedge clk);
         n++;
      end
      check_true(interrupt, "interrupt did not rise with the FIFO level at the threshold");
      // one of the six sits in the read controller
      csr_read(FIFO_LEVEL, rd);
      check_eq("FIFO_LEVEL", rd, 5);
      for (int i = 1; i <= 6; i++) begin
         csr_read(DATA, rd);
         check_eq("csr_rdata_o", rd, sent_q.pop_front());
         level_exp = 5 - i;
         if (level_exp < 0) begin
            level_exp = 0;
         end
         check_eq("interrupt_o", interrupt, level_exp >= 4);
      end
      csr_read(DATA, rd);
      check_eq("csr_rdata_o", rd, 0);
      csr_write(FIFO_THRESHOLD, 0);
      finish_test("cpu_interrupt", e0);
   endtask

   task automatic test_soft_reset();
      int               e0;
      logic [CSR_W-1:0] rd;
      e0 = errors;
      // leave words behind so the reset has something to clear
      send_words(3, 0);
      sent_q.delete();
      wait_cycles(10);
      apply_soft_reset();
      csr_read(FIFO_EMPTY, rd);
      check_eq("FIFO_EMPTY", rd, 1);
      csr_read(TLAST_DETECTED, rd);
      check_eq("TLAST_DETECTED", rd, 0);
      csr_read(NWORDS, rd);
      check_eq("NWORDS", rd, 0);
      @(negedge clk);
      check_eq("dma_tvalid_o", dma_tvalid, 0);
      finish_test("soft_reset", e0);
   endtask

   initial begin
      arst_n      = 1'b0;
      axis_tdata  = '0;
      axis_tvalid = 1'b0;
      axis_tlast  = 1'b0;
      dma_tready  = 1'b0;
      csr_req     = '0;
      rng         = 32'h4fe;
      errors      = 0;
      checks      = 0;
      repeat (8) @(posedge clk);
      arst_n <= 1'b1;

      test_reset_state();
      test_enable_order();
      test_backpressure();
      test_tlast_count();
      test_cpu_interrupt();
      test_soft_reset();

      // bound protocol assertions count toward the result
      errors += dut.u_asserts.fail_count;
      $display("checks run: %0d, checks failed: %0d", checks, errors);
      if (errors == 0) begin
         $display("Test completed successfully");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

endmodule

// File: compile.f
logic/axis_in_pkg.sv
logic/cdc_sync.sv
logic/async_fifo.sv
logic/stream_capture.sv
logic/read_ctrl.sv
logic/csr_block.sv
logic/axis_stream_in.sv
testbench/tb_clock_gen.sv
testbench/axis_stream_in_asserts.sv
testbench/axis_stream_in_tb.sv
